/* logic/tbu_defines.svh */
`ifndef TBU_DEFINES_SVH
`define TBU_DEFINES_SVH

// Trellis size of the K=7 code
`define TBU_NUM_STATES 64

// Bits needed to name one state
`define TBU_STATE_W 6

// Survivor memory columns, one stage word each
`define TBU_DEPTH 128

// Stages walked back before the survivor paths are trusted (X_MIN)
`define TBU_TRACE_LEN 30

// Decisions emitted per traceback (B)
`define TBU_BLOCK_LEN 30

`endif

/* logic/tbu_pkg.sv */
`default_nettype none

`include "tbu_defines.svh"

package tbu_pkg;

  typedef logic [`TBU_STATE_W-1:0] state_t;  // One trellis state

  typedef state_t [`TBU_NUM_STATES-1:0] prev_vec_t;  // Predecessor per state
  typedef logic [`TBU_NUM_STATES-1:0] dec_vec_t;  // Decision per state

  // Decision bit sits above the predecessor
  typedef struct packed {
    logic   dec;
    state_t prev;
  } survivor_t;

  typedef survivor_t [`TBU_NUM_STATES-1:0] stage_word_t;  // Indexed by state

  typedef logic [$clog2(`TBU_DEPTH)-1:0] col_t;
  typedef logic [4:0] blk_idx_t;  // Holds 0 to 29

  typedef enum logic [1:0] {ph_idle, ph_trace, ph_read} ptr_phase_t;

endpackage

`default_nettype wire

/* logic/survivor_write_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tbu_defines.svh"

module survivor_write_ctrl (
  input  wire logic              clk,
  input  wire logic              sys_rst,
  input  wire logic              valid_in,
  input  wire tbu_pkg::prev_vec_t prev_state,
  input  wire tbu_pkg::dec_vec_t  decision,
  output logic                   wr_en,
  output tbu_pkg::col_t          wr_col,
  output tbu_pkg::stage_word_t   wr_word,
  output tbu_pkg::col_t          stage_cnt
);

  localparam int DEPTH = `TBU_DEPTH;

  // Write strobe and column bookkeeping
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_en     <= 1'b0;
      wr_col    <= '0;
      stage_cnt <= '0;
    end else begin
      wr_en <= valid_in;
      if (wr_en) begin
        wr_col    <= (wr_col == tbu_pkg::col_t'(DEPTH - 1)) ? '0 : wr_col + 1'b1;
        stage_cnt <= stage_cnt + 1'b1;  // Wraps with the 7-bit type
      end
    end
  end

  // Stage word, one survivor entry per state
  always_ff @(posedge clk) begin
    if (valid_in) begin
      for (int s = 0; s < `TBU_NUM_STATES; s++) begin
        wr_word[s].dec  <= decision[s];
        wr_word[s].prev <= prev_state[s];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/survivor_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tbu_defines.svh"

module survivor_ram (
  input  wire logic                 clk,
  input  wire logic                 wr_en,
  input  wire tbu_pkg::col_t        wr_col,
  input  wire tbu_pkg::stage_word_t wr_word,
  input  wire tbu_pkg::col_t        rd_col,
  output tbu_pkg::stage_word_t      rd_word
);

  localparam int DEPTH = `TBU_DEPTH;

  tbu_pkg::stage_word_t mem [DEPTH];

  // Read-first behaviour, a colliding read sees the old word
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_col] <= wr_word;
    end
    rd_word <= mem[rd_col];  // Registered read
  end

endmodule

`default_nettype wire

/* logic/traceback_ptr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tbu_defines.svh"

module traceback_ptr #(
  parameter int FIRST_END = 59
) (
  input  wire logic                 clk,
  input  wire logic                 sys_rst,
  input  wire logic                 valid_in,
  input  wire tbu_pkg::col_t        stage_cnt,
  output tbu_pkg::col_t             rd_col,
  input  wire tbu_pkg::stage_word_t rd_word,
  output logic                      bit_valid,
  output logic                      bit_val
);

  localparam int X_MIN = `TBU_TRACE_LEN;
  localparam int B     = `TBU_BLOCK_LEN;
  localparam int DEPTH = `TBU_DEPTH;

  tbu_pkg::ptr_phase_t phase;
  tbu_pkg::blk_idx_t   cnt;        // Steps issued in the current phase
  tbu_pkg::col_t       col;        // Column for the next read
  tbu_pkg::col_t       start_col;  // Column where this traceback began
  tbu_pkg::state_t     st;         // Current state on the survivor path
  logic                pend;       // Read data arrives this cycle
  logic                pend_emit;  // That data belongs to the read phase

  tbu_pkg::survivor_t  entry;
  tbu_pkg::col_t       col_prev;
  tbu_pkg::col_t       next_start;
  logic                start_hit;
  logic                issue;
  logic                first_step;

  assign rd_col = col;
  assign entry  = rd_word[st];

  // One column back, wrapping below zero
  assign col_prev   = (col == '0) ? tbu_pkg::col_t'(DEPTH - 1) : col - 1'b1;
  assign next_start = tbu_pkg::col_t'((int'(start_col) + 2 * B) % DEPTH);

  assign start_hit  = (stage_cnt == tbu_pkg::col_t'(FIRST_END + 1));
  assign issue      = valid_in && ((phase != tbu_pkg::ph_idle) || start_hit);
  assign first_step = (phase == tbu_pkg::ph_idle) ||
                      ((phase == tbu_pkg::ph_trace) && (cnt == '0));

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      phase     <= tbu_pkg::ph_idle;
      cnt       <= '0;
      col       <= tbu_pkg::col_t'(FIRST_END);
      start_col <= tbu_pkg::col_t'(FIRST_END);
      st        <= '0;
      pend      <= 1'b0;
      pend_emit <= 1'b0;
      bit_valid <= 1'b0;
    end else begin
      pend      <= issue;
      bit_valid <= pend && pend_emit;

      // Follow the predecessor of the selected entry
      if (pend) begin
        st <= entry.prev;
      end

      if (issue) begin
        pend_emit <= (phase == tbu_pkg::ph_read);
        if (first_step) begin
          st <= '0;  // Every traceback starts in state 0
        end

        case (phase)
          tbu_pkg::ph_read: begin
            if (cnt == tbu_pkg::blk_idx_t'(B - 1)) begin
              // Block done, jump ahead two blocks
              phase     <= tbu_pkg::ph_trace;
              cnt       <= '0;
              col       <= next_start;
              start_col <= next_start;
            end else begin
              cnt <= cnt + 1'b1;
              col <= col_prev;
            end
          end
          default: begin  // Idle start counts as the first traceback step
            if (cnt == tbu_pkg::blk_idx_t'(X_MIN - 1)) begin
              phase <= tbu_pkg::ph_read;
              cnt   <= '0;
            end else begin
              phase <= tbu_pkg::ph_trace;
              cnt   <= cnt + 1'b1;
            end
            col <= col_prev;
          end
        endcase
      end
    end
  end

  // Decision bit travels alongside bit_valid
  always_ff @(posedge clk) begin
    if (pend) begin
      bit_val <= entry.dec;
    end
  end

endmodule

`default_nettype wire

/* logic/block_reverser.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tbu_defines.svh"

module block_reverser (
  input  wire logic clk,
  input  wire logic sys_rst,
  input  wire logic bit_valid,
  input  wire logic bit_val,
  output logic      dec_valid,
  output logic      dec_bit
);

  localparam int B = `TBU_BLOCK_LEN;

  logic              buf_mem [B];
  tbu_pkg::blk_idx_t idx;
  logic              dir_up;  // Index climbs when set
  logic              seen;    // A full block is already stored
  logic              at_end;

  // Last slot in the current direction
  assign at_end = dir_up ? (idx == tbu_pkg::blk_idx_t'(B - 1)) : (idx == '0);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      idx       <= '0;
      dir_up    <= 1'b1;
      seen      <= 1'b0;
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= bit_valid && seen;
      if (bit_valid) begin
        if (at_end) begin
          // Stay on the end slot, next block walks the other way
          dir_up <= ~dir_up;
          seen   <= 1'b1;
        end else if (dir_up) begin
          idx <= idx + 1'b1;
        end else begin
          idx <= idx - 1'b1;
        end
      end
    end
  end

  // Old slot goes out while the new bit goes in
  always_ff @(posedge clk) begin
    if (bit_valid) begin
      buf_mem[idx] <= bit_val;
      dec_bit      <= buf_mem[idx];
    end
  end

endmodule

`default_nettype wire

/* logic/viterbi_tbu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tbu_defines.svh"

module viterbi_tbu (
  input  wire logic               clk,
  input  wire logic               sys_rst,
  input  wire logic               valid_in,  // Never high two cycles in a row
  input  wire tbu_pkg::prev_vec_t prev_state,
  input  wire tbu_pkg::dec_vec_t  decision,
  output logic                    dec_valid,
  output logic                    dec_bit
);

  // Stage that closes the first traceback of each pointer
  localparam int END_EVEN = `TBU_TRACE_LEN + `TBU_BLOCK_LEN - 1;
  localparam int END_ODD  = END_EVEN + `TBU_BLOCK_LEN;

  logic                 wr_en;
  tbu_pkg::col_t        wr_col;
  tbu_pkg::stage_word_t wr_word;
  tbu_pkg::col_t        stage_cnt;

  tbu_pkg::col_t        rd_col_even;
  tbu_pkg::col_t        rd_col_odd;
  tbu_pkg::stage_word_t rd_word_even;
  tbu_pkg::stage_word_t rd_word_odd;

  logic bit_valid_even;
  logic bit_valid_odd;
  logic bit_val_even;
  logic bit_val_odd;
  logic bit_valid;
  logic bit_val;

  survivor_write_ctrl u_writer (
    .clk, .sys_rst, .valid_in, .prev_state, .decision,
    .wr_en, .wr_col, .wr_word, .stage_cnt
  );

  // One memory per pointer so both can read every cycle
  survivor_ram u_ram_even (
    .clk, .wr_en, .wr_col, .wr_word,
    .rd_col (rd_col_even),
    .rd_word(rd_word_even)
  );

  survivor_ram u_ram_odd (
    .clk, .wr_en, .wr_col, .wr_word,
    .rd_col (rd_col_odd),
    .rd_word(rd_word_odd)
  );

  traceback_ptr #(.FIRST_END(END_EVEN)) u_ptr_even (
    .clk, .sys_rst, .valid_in, .stage_cnt,
    .rd_col   (rd_col_even),
    .rd_word  (rd_word_even),
    .bit_valid(bit_valid_even),
    .bit_val  (bit_val_even)
  );

  traceback_ptr #(.FIRST_END(END_ODD)) u_ptr_odd (
    .clk, .sys_rst, .valid_in, .stage_cnt,
    .rd_col   (rd_col_odd),
    .rd_word  (rd_word_odd),
    .bit_valid(bit_valid_odd),
    .bit_val  (bit_val_odd)
  );

  // Read phases never overlap, a plain OR merges them
  assign bit_valid = bit_valid_even | bit_valid_odd;
  assign bit_val   = (bit_valid_even & bit_val_even) | (bit_valid_odd & bit_val_odd);

  block_reverser u_reverser (
    .clk, .sys_rst, .bit_valid, .bit_val, .dec_valid, .dec_bit
  );

endmodule

`default_nettype wire

/* tests/viterbi_tbu_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module viterbi_tbu_chk (
  input wire logic clk,
  input wire logic sys_rst,
  input wire logic valid_in,
  input wire logic emit_even,
  input wire logic emit_odd,
  input wire logic dec_valid
);

  // Input stages come at most every other cycle
  property p_valid_spacing;
    @(posedge clk) disable iff (sys_rst) valid_in |=> !valid_in;
  endproperty

  // Read phases of the two pointers interleave
  property p_emit_exclusive;
    @(posedge clk) disable iff (sys_rst) !(emit_even && emit_odd);
  endproperty

  property p_quiet_after_reset;
    @(posedge clk) sys_rst |=> !dec_valid;
  endproperty

  a_valid_spacing: assert property (p_valid_spacing)
    else $error("valid_in high on two consecutive cycles");

  a_emit_exclusive: assert property (p_emit_exclusive)
    else $error("both traceback pointers emitting in the same cycle");

  a_quiet_after_reset: assert property (p_quiet_after_reset)
    else $error("dec_valid high in the cycle after reset");

endmodule

bind viterbi_tbu viterbi_tbu_chk u_chk (
  .clk      (clk),
  .sys_rst  (sys_rst),
  .valid_in (valid_in),
  .emit_even(bit_valid_even),
  .emit_odd (bit_valid_odd),
  .dec_valid(dec_valid)
);

`default_nettype wire

/* tests/tb_viterbi_tbu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tbu_defines.svh"

module tb_viterbi_tbu;

  localparam int X_MIN    = `TBU_TRACE_LEN;
  localparam int B        = `TBU_BLOCK_LEN;
  localparam int MAX_STG  = 512;
  localparam int WAIT_MAX = 2000;  // Cycles allowed for any single wait

  logic               clk;
  logic               sys_rst;
  logic               valid_in;
  tbu_pkg::prev_vec_t prev_state;
  tbu_pkg::dec_vec_t  decision;
  logic               dec_valid;
  logic               dec_bit;

  // Reference trellis with one entry per stage sent
  tbu_pkg::prev_vec_t tr_prev [MAX_STG];
  tbu_pkg::dec_vec_t  tr_dec  [MAX_STG];

  logic got_q [$];  // Bits seen on dec_bit
  int   err_cnt;

  viterbi_tbu u_viterbi_tbu (
    .clk, .sys_rst, .valid_in, .prev_state, .decision, .dec_valid, .dec_bit
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Collector samples on the falling edge where outputs are stable
  always @(negedge clk) begin
    if (dec_valid === 1'b1) begin
      got_q.push_back(dec_bit);
    end
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      err_cnt++;
      $display("Mismatch at %0t: %s, got %0d expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    sys_rst  = 1'b1;
    valid_in = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    sys_rst = 1'b0;
    got_q.delete();  // Anything before reset is stale
  endtask

  task automatic make_trellis(input int n);
    for (int i = 0; i < n; i++) begin
      for (int s = 0; s < `TBU_NUM_STATES; s++) begin
        tr_prev[i][s] = tbu_pkg::state_t'($urandom);
      end
      tr_dec[i] = {$urandom, $urandom};
    end
  endtask

  // One stage followed by idle cycles so the next one starts gap cycles later
  task automatic send_stage(input int idx, input int gap);
    @(posedge clk);
    #1;
    valid_in   = 1'b1;
    prev_state = tr_prev[idx];
    decision   = tr_dec[idx];
    @(posedge clk);
    #1;
    valid_in = 1'b0;
    repeat (gap - 2) @(posedge clk);
  endtask

  task automatic feed_trellis(input int n, input bit rand_gap);
    int gap;
    for (int i = 0; i < n; i++) begin
      gap = rand_gap ? 2 + int'($urandom % 4) : 2;
      send_stage(i, gap);
    end
  endtask

  // Walk back from the end of the stage's block from state 0
  function automatic logic expected_bit(input int stage);
    int              k;
    int              e;
    tbu_pkg::state_t r;
    logic            b;
    k = stage / B;
    e = X_MIN + B * (k + 1) - 1;
    r = '0;
    b = 1'b0;
    for (int j = e; j >= B * k; j--) begin
      if (j == stage) begin
        b = tr_dec[j][r];
      end
      r = tr_prev[j][r];
    end
    return b;
  endfunction

  // Each input from stage 2*X_MIN+B on carries one read step,
  // and the first block never leaves the reverser
  function automatic int out_count(input int n);
    int cnt;
    cnt = n - 2 * X_MIN - 2 * B;
    return (cnt > 0) ? cnt : 0;
  endfunction

  task automatic wait_for_bits(input int n);
    int cycles;
    cycles = 0;
    while (got_q.size() < n) begin
      if (cycles >= WAIT_MAX) begin
        $display("Timed out waiting for %0d output bits, only %0d arrived", n, got_q.size());
        abort_run();
      end else begin
        @(posedge clk);
        cycles++;
      end
    end
  endtask

  task automatic finish_and_check(input int n);
    int exp_cnt;
    exp_cnt = out_count(n);
    wait_for_bits(exp_cnt);
    repeat (10) @(posedge clk);  // Catch any surplus bits
    check_count(got_q.size(), exp_cnt, "output bit count");
    for (int i = 0; i < got_q.size(); i++) begin
      check_bit(got_q[i], expected_bit(i), $sformatf("decoded bit of stage %0d", i));
    end
  endtask

  task automatic test_idle_after_reset();
    apply_reset();
    repeat (20) @(posedge clk);
    check_count(got_q.size(), 0, "outputs with no input");
  endtask

  task automatic test_short_feed();
    apply_reset();
    make_trellis(120);
    feed_trellis(89, 1'b0);
    repeat (20) @(posedge clk);
    check_count(got_q.size(), 0, "outputs after 89 stages");
    // Block 0 fills the reverser but must stay inside
    for (int i = 89; i < 120; i++) begin
      send_stage(i, 2);
    end
    repeat (20) @(posedge clk);
    check_count(got_q.size(), 0, "outputs with only block 0 decoded");
  endtask

  task automatic test_steady_rate();
    apply_reset();
    make_trellis(300);
    feed_trellis(300, 1'b0);
    finish_and_check(300);
  endtask

  // Same trellis as the steady-rate run
  task automatic test_random_gaps();
    apply_reset();
    feed_trellis(300, 1'b1);
    finish_and_check(300);
  endtask

  task automatic test_memory_wrap();
    apply_reset();
    make_trellis(400);
    feed_trellis(400, 1'b0);
    finish_and_check(400);
  endtask

  task automatic test_reset_mid_run();
    apply_reset();
    make_trellis(200);
    feed_trellis(200, 1'b0);
    apply_reset();  // Pointers and reverser are mid-block here
    make_trellis(200);
    feed_trellis(200, 1'b0);
    finish_and_check(200);
  endtask

  initial begin
    err_cnt    = 0;
    sys_rst    = 1'b1;
    valid_in   = 1'b0;
    prev_state = '0;
    decision   = '0;
    void'($urandom(32'h9b53));

    test_idle_after_reset();
    test_short_feed();
    test_steady_rate();
    test_random_gaps();
    test_memory_wrap();
    test_reset_mid_run();

    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/tbu_pkg.sv
logic/survivor_write_ctrl.sv
logic/survivor_ram.sv
logic/traceback_ptr.sv
logic/block_reverser.sv
logic/viterbi_tbu.sv
tests/viterbi_tbu_chk.sv
tests/tb_viterbi_tbu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the Viterbi traceback testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_viterbi_tbu \
  --Mdir obj_dir -o tb_viterbi_tbu \
  || { echo "Build failed"; exit 1; }

out="$(./obj_dir/tb_viterbi_tbu 2>&1)"
echo "$out"

echo "$out" | grep -q "Simulation passed" \
  && { echo "Result: PASS"; exit 0; } \
  || { echo "Result: FAIL"; exit 1; }
